//--- src/noc_pkg.sv
// shared widths, port indices and flit types
// for the mesh router.
`default_nettype none

package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int COORD_W   = 2;   // bits per mesh coordinate.
  localparam int DATA_W    = 16;  // payload bits.
  localparam int NUM_PORTS = 5;
  localparam int PORT_W    = 3;   // port index bits.

  // port order is fixed, all arrays are indexed by it.
  typedef enum logic [PORT_W-1:0] {
    PORT_NORTH = 3'd0,
    PORT_SOUTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_WEST  = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // flit types
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } coord_t;

  // single flit carries a whole packet.
  typedef struct packed {
    coord_t             dest;
    logic [DATA_W-1:0]  data;  // opaque to the router.
  } flit_t;

  typedef logic [NUM_PORTS-1:0] port_mask_t;  // one bit per port.

endpackage

`default_nettype wire

//--- src/input_fifo.sv
// per-port input queue, circular buffer
// with first-word fall-through head.
`default_nettype none

module input_fifo #(
  parameter type item_t     = noc_pkg::flit_t,
  parameter int  FIFO_DEPTH = 4
) (
  input  wire logic  clk,
  input  wire logic  arst_n_i,
  input  wire logic  wr_i,
  input  wire item_t data_i,
  input  wire logic  pop_i,
  output item_t      head_o,
  output logic       nonempty_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  item_t             mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;

  // pointers wrap on their own, depth is a power of two.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (wr_i && !pop_i) cnt_q <= cnt_q + 1'b1;
      else if (pop_i && !wr_i) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign head_o     = mem_q[rd_ptr_q];  // oldest entry.
  assign nonempty_o = (cnt_q != '0);

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~
  // upstream holds its own credits, so a full queue is never written.
  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    !(wr_i && cnt_q == CNT_W'(FIFO_DEPTH)))
    else $error("input queue written while full");

  // pop comes from an arbiter grant, which needs a valid head.
  a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    !(pop_i && cnt_q == '0))
    else $error("input queue popped while empty");

endmodule

`default_nettype wire

//--- src/xy_route.sv
// dimension-order (XY) route computation for one head flit.
`default_nettype none

module xy_route (
  input  wire logic               valid_i,
  input  wire noc_pkg::coord_t    dest_i,
  input  wire noc_pkg::coord_t    my_addr_i,
  output noc_pkg::port_mask_t     req_o
);

  // x first, then y, local when both match.
  always_comb begin
    req_o = '0;
    if (valid_i) begin
      if (dest_i.x > my_addr_i.x)      req_o[noc_pkg::PORT_EAST]  = 1'b1;
      else if (dest_i.x < my_addr_i.x) req_o[noc_pkg::PORT_WEST]  = 1'b1;
      else if (dest_i.y > my_addr_i.y) req_o[noc_pkg::PORT_NORTH] = 1'b1;
      else if (dest_i.y < my_addr_i.y) req_o[noc_pkg::PORT_SOUTH] = 1'b1;
      else                             req_o[noc_pkg::PORT_LOCAL] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/output_arbiter.sv
// round-robin arbiter for one output port,
// held off while the downstream has no credit.
`default_nettype none

module output_arbiter (
  input  wire logic                 clk,
  input  wire logic                 arst_n_i,
  input  wire noc_pkg::port_mask_t  req_i,
  input  wire logic                 have_credit_i,
  output noc_pkg::port_mask_t       grant_o
);

  logic [noc_pkg::PORT_W-1:0] ptr_q;    // highest priority input.
  logic [noc_pkg::PORT_W-1:0] win;
  logic [noc_pkg::PORT_W-1:0] ptr_nxt;
  logic                       found;

  // ~~~~~~~~~~~~~~~~~~~~
  // search
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    int idx;
    grant_o = '0;
    found   = 1'b0;
    win     = ptr_q;
    for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= noc_pkg::NUM_PORTS) idx -= noc_pkg::NUM_PORTS;  // wrap.
      if (!found && req_i[idx] && have_credit_i) begin
        grant_o[idx] = 1'b1;
        found        = 1'b1;
        win          = idx[noc_pkg::PORT_W-1:0];
      end
    end
  end

  // next pointer sits just past the winner.
  always_comb begin
    if (win == noc_pkg::PORT_W'(noc_pkg::NUM_PORTS - 1)) ptr_nxt = '0;
    else ptr_nxt = win + 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= noc_pkg::PORT_NORTH;
    end else if (found) begin
      ptr_q <= ptr_nxt;  // only moves on a grant.
    end
  end

endmodule

`default_nettype wire

//--- src/credit_counter.sv
// downstream credit count for one output port.
`default_nettype none

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  wire logic clk,
  input  wire logic arst_n_i,
  input  wire logic credit_i,      // returned credit pulse.
  input  wire logic sent_i,        // flit granted to this output.
  output logic      have_credit_o
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] cnt_q;

  // saturates at both ends, inc and dec together cancel.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= CNT_W'(CREDITS);
    end else if (credit_i && !sent_i) begin
      if (cnt_q != CNT_W'(CREDITS)) cnt_q <= cnt_q + 1'b1;
    end else if (sent_i && !credit_i) begin
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
    end
  end

  assign have_credit_o = (cnt_q != '0);

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~
  // the downstream never returns more than it was given.
  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    !(credit_i && !sent_i && cnt_q == CNT_W'(CREDITS)))
    else $error("credit returned above initial count");

  // the arbiter must not send without a credit.
  a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    !(sent_i && !credit_i && cnt_q == '0))
    else $error("flit sent with no credit");

endmodule

`default_nettype wire

//--- src/xbar.sv
// crossbar: granted head flits muxed onto
// registered output flits and valids.
`default_nettype none

module xbar (
  input  wire logic                                           clk,
  input  wire logic                                           arst_n_i,
  input  wire noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]        head_i,
  input  wire noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0]   grant_i,
  output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]             out_flit_o,
  output noc_pkg::port_mask_t                                 out_valid_o
);

  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] flit_d;

  // grant is one-hot or zero, so an OR of gated heads is enough.
  always_comb begin
    flit_d = '0;
    for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (grant_i[j][i]) flit_d[j] = flit_d[j] | head_i[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    out_flit_o <= flit_d;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= '0;
    end else begin
      for (int j = 0; j < noc_pkg::NUM_PORTS; j++) begin
        out_valid_o[j] <= |grant_i[j];  // one pulse per flit.
      end
    end
  end

  // an input asks for one output only, so no two outputs pop it.
  for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_chk
    a_single_pop : assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({grant_i[4][i], grant_i[3][i], grant_i[2][i], grant_i[1][i], grant_i[0][i]}))
      else $error("input %0d granted by two outputs", i);
  end

endmodule

`default_nettype wire

//--- src/router.sv
// five-port mesh router top level: input queues, XY route,
// per-output arbiters and credit counters, crossbar.
`default_nettype none

module router #(
  parameter int FIFO_DEPTH = 4,
  parameter int CREDITS    = 4
) (
  input  wire logic                                          clk,
  input  wire logic                                          arst_n_i,
  input  wire noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]       in_flit_i,
  input  wire noc_pkg::port_mask_t                           in_valid_i,
  input  wire noc_pkg::port_mask_t                           credit_i,
  input  wire noc_pkg::coord_t                               my_addr_i,
  output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]            out_flit_o,
  output noc_pkg::port_mask_t                                out_valid_o
);

  localparam int N = noc_pkg::NUM_PORTS;

  noc_pkg::flit_t [N-1:0]       head;
  noc_pkg::port_mask_t          nonempty;
  noc_pkg::port_mask_t [N-1:0]  req;        // by input.
  noc_pkg::port_mask_t [N-1:0]  req_t;      // by output.
  noc_pkg::port_mask_t [N-1:0]  grant;      // by output.
  noc_pkg::port_mask_t [N-1:0]  grant_t;    // by input.
  noc_pkg::port_mask_t          pop;
  noc_pkg::port_mask_t          sent;
  noc_pkg::port_mask_t          have_credit;

  // ~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < N; i++) begin : g_in
    input_fifo #(
      .item_t     (noc_pkg::flit_t),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .wr_i       (in_valid_i[i]),
      .data_i     (in_flit_i[i]),
      .pop_i      (pop[i]),
      .head_o     (head[i]),
      .nonempty_o (nonempty[i])
    );

    xy_route route_i (
      .valid_i   (nonempty[i]),
      .dest_i    (head[i].dest),
      .my_addr_i (my_addr_i),
      .req_o     (req[i])
    );
  end

  // request and grant matrices swap their index.
  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      assign req_t[j][i]   = req[i][j];
      assign grant_t[i][j] = grant[j][i];
    end
    assign pop[i] = |grant_t[i];
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar j = 0; j < N; j++) begin : g_out
    assign sent[j] = |grant[j];

    output_arbiter arb_i (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .req_i         (req_t[j]),
      .have_credit_i (have_credit[j]),
      .grant_o       (grant[j])
    );

    credit_counter #(
      .CREDITS (CREDITS)
    ) credit_i_cnt (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .credit_i      (credit_i[j]),
      .sent_i        (sent[j]),
      .have_credit_o (have_credit[j])
    );
  end

  xbar xbar_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .head_i      (head),
    .grant_i     (grant),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o)
  );

endmodule

`default_nettype wire

//--- sim/router_tb.sv
// testbench for the mesh router: clock, reset, LCG stimulus,
// reference XY routing, scoreboard compare and timeout.
`default_nettype none

module router_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIFO_DEPTH  = 4;
  localparam int CREDITS     = 4;
  localparam int N           = noc_pkg::NUM_PORTS;
  localparam int RAND_FLITS  = 300;
  localparam int FAIR_FLITS  = 80;
  localparam int TOTAL_FLITS = 16 + RAND_FLITS + 6 + FAIR_FLITS;
  localparam int TIMEOUT_CYC = 8 * TOTAL_FLITS + 200;

  logic                    clk;
  logic                    arst_n_i;
  noc_pkg::flit_t [N-1:0]  in_flit_i;
  noc_pkg::port_mask_t     in_valid_i;
  noc_pkg::port_mask_t     credit_i;
  noc_pkg::coord_t         my_addr_i;
  noc_pkg::flit_t [N-1:0]  out_flit_o;
  noc_pkg::port_mask_t     out_valid_o;

  noc_pkg::flit_t exp_q [N*N][$];  // source * N + output.
  int             occ [N];         // model of input queue fill.
  int             pend [N];        // credits owed per output.
  int             since [N];       // local flits since a source's last one.
  logic [12:0]    seq [N];
  int             sent_cnt;
  int             recv_cnt;
  int             east_cnt;
  logic           fair_on;
  logic [31:0]    rng_state;

  router #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDITS    (CREDITS)
  ) dut_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_flit_i   (in_flit_i),
    .in_valid_i  (in_valid_i),
    .credit_i    (credit_i),
    .my_addr_i   (my_addr_i),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o)
  );

  initial begin : clock
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // x first, then y, local when both match.
  function automatic int expected_port(input noc_pkg::coord_t d, input noc_pkg::coord_t me);
    if (d.x != me.x) return (d.x > me.x) ? noc_pkg::PORT_EAST : noc_pkg::PORT_WEST;
    if (d.y > me.y) return noc_pkg::PORT_NORTH;
    if (d.y < me.y) return noc_pkg::PORT_SOUTH;
    return noc_pkg::PORT_LOCAL;
  endfunction

  function automatic int pend_sum();
    int s;
    s = 0;
    for (int j = 0; j < N; j++) s += pend[j];
    return s;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic draw(output int v);
    rng_state = lcg_next(rng_state);
    v = int'(rng_state[30:16]);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
    in_valid_i = '0;  // strobes last one cycle.
    credit_i   = '0;
  endtask

  // data holds source in the top bits, then a sequence number.
  task automatic send_flit(input int src, input noc_pkg::coord_t dest);
    noc_pkg::flit_t f;
    f.dest = dest;
    f.data = {3'(src), seq[src]};
    in_flit_i[src]  = f;
    in_valid_i[src] = 1'b1;
    exp_q[src * N + expected_port(dest, my_addr_i)].push_back(f);
    occ[src]++;
    seq[src]++;
    sent_cnt++;
  endtask

  task automatic return_credits(input int pct);
    int r;
    for (int j = 0; j < N; j++) begin
      draw(r);
      if (pend[j] > 0 && r % 100 < pct) begin
        credit_i[j] = 1'b1;
        pend[j]--;
      end
    end
  endtask

  task automatic drain();
    while (recv_cnt != sent_cnt || pend_sum() != 0) begin
      next_cycle();
      return_credits(100);
    end
    next_cycle();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // compare
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic note_local(input int src);
    if (since[src] >= 0) begin
      assert (since[src] <= 3)
        else stop_on_error($sformatf(
          "local output served %0d other flits between two from input %0d", since[src], src));
    end
    for (int k = 0; k < N; k++) begin
      if (k != src && since[k] >= 0) since[k]++;
    end
    since[src] = 0;
  endtask

  task automatic check_output(input int j);
    noc_pkg::flit_t got;
    noc_pkg::flit_t want;
    int src;
    got = out_flit_o[j];
    src = int'(got.data[15:13]);
    assert (src < N && exp_q[src * N + j].size() > 0)
      else stop_on_error($sformatf("flit %h on output %0d was never sent there", got, j));
    want = exp_q[src * N + j].pop_front();
    assert (got == want)
      else stop_on_error($sformatf("Fail out_flit_o[%0d]: expected %h, got %h", j, want, got));
    occ[src]--;    // a popped flit frees its input slot.
    pend[j]++;
    recv_cnt++;
    if (j == noc_pkg::PORT_EAST) east_cnt++;
    if (fair_on && j == noc_pkg::PORT_LOCAL) note_local(src);
  endtask

  initial begin : compare
    @(posedge arst_n_i);
    forever begin
      @(negedge clk);  // outputs settled mid-cycle.
      if (sent_cnt == 0) begin
        assert (out_valid_o == '0)
          else stop_on_error("output valid seen before any flit was sent");
      end
      for (int j = 0; j < N; j++) begin
        if (out_valid_o[j]) check_output(j);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      assert (cycles <= TIMEOUT_CYC)
        else stop_on_error("timeout, the router stopped delivering flits");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    noc_pkg::coord_t d;
    int r;
    int n;
    int base;
    rng_state  = 32'd52;
    arst_n_i   = 1'b0;
    in_flit_i  = '0;
    in_valid_i = '0;
    credit_i   = '0;
    my_addr_i  = '{x: 2'd1, y: 2'd1};
    sent_cnt   = 0;
    recv_cnt   = 0;
    east_cnt   = 0;
    fair_on    = 1'b0;
    for (int i = 0; i < N; i++) begin
      occ[i]   = 0;
      pend[i]  = 0;
      since[i] = -1;
      seq[i]   = '0;
    end
    repeat (16) @(posedge clk);
    #10;
    arst_n_i = 1'b1;
    repeat (5) next_cycle();  // idle, outputs must stay low.

    // every x and y relation to (1,1).
    for (int k = 0; k < 16; k++) begin
      d = '{x: 2'(k % 4), y: 2'(k / 4)};
      next_cycle();
      while (occ[k % N] >= FIFO_DEPTH) next_cycle();
      send_flit(k % N, d);
      return_credits(100);
    end
    drain();

    // random traffic with random gaps and credit returns.
    n = 0;
    while (n < RAND_FLITS) begin
      next_cycle();
      for (int i = 0; i < N; i++) begin
        draw(r);
        if (n < RAND_FLITS && occ[i] < FIFO_DEPTH && r % 4 != 0) begin
          d.x = r[5:4];
          d.y = r[7:6];
          send_flit(i, d);
          n++;
        end
      end
      return_credits(50);
    end
    drain();

    // east back-pressure, nothing returned until released.
    base = east_cnt;
    d    = '{x: 2'd3, y: 2'd1};
    repeat (3) begin
      next_cycle();
      send_flit(noc_pkg::PORT_NORTH, d);
      send_flit(noc_pkg::PORT_WEST, d);
    end
    while (east_cnt < base + CREDITS) next_cycle();
    repeat (20) next_cycle();
    assert (east_cnt == base + CREDITS)
      else stop_on_error("east output sent a flit with no credit left");
    next_cycle();
    credit_i[noc_pkg::PORT_EAST] = 1'b1;
    pend[noc_pkg::PORT_EAST]--;
    while (east_cnt < base + CREDITS + 1) next_cycle();
    repeat (20) next_cycle();
    assert (east_cnt == base + CREDITS + 1)
      else stop_on_error("one returned credit released more than one east flit");
    drain();

    // four inputs keep the local output busy.
    fair_on = 1'b1;
    n = 0;
    while (n < FAIR_FLITS) begin
      next_cycle();
      for (int i = 0; i < 4; i++) begin
        if (n < FAIR_FLITS && occ[i] < FIFO_DEPTH) begin
          send_flit(i, my_addr_i);
          n++;
        end
      end
      return_credits(100);
    end
    drain();
    fair_on = 1'b0;

    repeat (10) next_cycle();  // idle, no stray flits may appear.
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/noc_pkg.sv
src/input_fifo.sv
src/xy_route.sv
src/output_arbiter.sv
src/credit_counter.sv
src/xbar.sv
src/router.sv
sim/router_tb.sv
